//--- logic/cabinet_pkg.sv
package cabinet_pkg;

	typedef logic [4:0] game_t;

	// Mode codes of the supported games
	localparam game_t GAME_CARNIVAL = 5'd3;
	localparam game_t GAME_DIGGER = 5'd4;
	localparam game_t GAME_FROGS = 5'd5;
	localparam game_t GAME_HEADON = 5'd6;
	localparam game_t GAME_HEIANKYO = 5'd8;
	localparam game_t GAME_SPACEATTACK = 5'd15;

	// Active high, one player
	typedef struct packed
	{
		logic fire3;
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_ctrl_t;

	typedef struct packed
	{
		player_ctrl_t p1;
		player_ctrl_t p2;
		logic start1;
		logic start2;
	} cabinet_ctrl_t;

	// Active low input ports as the core reads them
	typedef struct packed
	{
		logic [7:0] p1;
		logic [7:0] p2;
		logic [7:0] p3;
		logic [7:0] p4;
	} in_ports_t;

	// Space Attack lives field
	localparam logic [2:0] LIVES_3 = 3'd7;
	localparam logic [2:0] LIVES_4 = 3'd6;
	localparam logic [2:0] LIVES_5 = 3'd5;
	localparam logic [2:0] LIVES_6 = 3'd3;

endpackage

//--- logic/download_regs.sv
module download_regs
	import loader_pkg::*, cabinet_pkg::*;
#(
	parameter int DIP_BYTES = 8
)
(
	input  logic clk_sys,
	input  logic arst_n,
	input  dl_stream_t dl,
	input  logic reset_request,
	output game_t game_mode,
	output logic [7:0] dip0,
	output logic core_reset
);

	logic [7:0] dip [DIP_BYTES];
	logic download_d;
	logic rom_loaded;

	// Game mode and DIP bytes from the loader stream
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			game_mode <= '0;
			for (int i = 0; i < DIP_BYTES; i++)
			begin
				dip[i] <= '0;
			end
		end
		else if (dl.wr)
		begin
			if (dl.index == INDEX_GAME)
			begin
				game_mode <= dl.data[4:0];
			end
			if (dl.index == INDEX_DIPS)
			begin
				for (int i = 0; i < DIP_BYTES; i++)
				begin
					if (dl.addr == dl_addr_t'(i))
					begin
						dip[i] <= dl.data;
					end
				end
			end
		end
	end

	assign dip0 = dip[0];

	// End of ROM download releases the core
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end
		else
		begin
			download_d <= dl.download;
			if (download_d && !dl.download)
			begin
				rom_loaded <= 1'b1;
			end
			core_reset <= reset_request || !rom_loaded;
		end
	end

endmodule

//--- logic/input_port_encoder.sv
module input_port_encoder
	import cabinet_pkg::*;
(
	input  logic clk_sys,
	input  logic arst_n,
	input  game_t game_mode,
	input  logic [7:0] dip0,
	input  cabinet_ctrl_t ctrl,
	output in_ports_t ports
);

	logic simultaneous;
	player_ctrl_t joy;
	player_ctrl_t p1;
	player_ctrl_t p2;
	logic [2:0] sa_lives;
	in_ports_t ports_next;

	// Only Heiankyo in two-player mode keeps the players apart
	assign simultaneous = (game_mode == GAME_HEIANKYO) && !dip0[0];
	assign joy = ctrl.p1 | ctrl.p2;
	assign p1 = simultaneous ? ctrl.p1 : joy;
	assign p2 = simultaneous ? ctrl.p2 : joy;

	always_comb
	begin
		case (dip0[2:1])
			2'd0: sa_lives = LIVES_3;
			2'd1: sa_lives = LIVES_4;
			2'd2: sa_lives = LIVES_5;
			default: sa_lives = LIVES_6;
		endcase
	end

	always_comb
	begin
		ports_next = '1;
		case (game_mode)
			GAME_CARNIVAL:
			begin
				ports_next.p1 = {3'b111, dip0[0], 4'b1111};
				ports_next.p2 = {2'b11, ~p1.right, ~p1.left, 4'b1011};
				ports_next.p3 = {2'b11, ~p1.fire1, ~ctrl.start1, 4'b1111};
				ports_next.p4 = {2'b11, ~ctrl.start2, 5'b11111};
			end
			GAME_DIGGER:
			begin
				ports_next.p1 = {~p1.up, ~p1.left, ~p1.down, ~p1.right,
					~p1.fire2, ~p1.fire1, ~ctrl.start2, ~ctrl.start1};
				ports_next.p3 = {6'b111111, dip0[1:0]};
			end
			GAME_FROGS:
			begin
				ports_next.p1 = {~p1.fire1, dip0[3:0], ~p1.left, ~p1.up, ~p1.right};
			end
			GAME_HEADON:
			begin
				// Demo sounds bit sits above the two lives bits
				ports_next.p1 = {~p1.up, ~p1.left, ~p1.down, ~p1.right, ~p1.fire1,
					dip0[0], dip0[2], dip0[1]};
			end
			GAME_HEIANKYO:
			begin
				ports_next.p1 = {2'b11, ~p1.fire1, ~p1.up, dip0[0], 1'b1, ~p2.fire2, ~p2.up};
				ports_next.p2 = {2'b11, ~p1.fire2, ~p1.right, 2'b01, ~p2.fire2, ~p2.right};
				ports_next.p3 = {3'b110, ~p1.down, 3'b110, ~p1.down};
				ports_next.p4 = {2'b11, ~ctrl.start1, ~p1.left, 1'b1, dip0[1],
					~ctrl.start2, ~p2.left};
			end
			GAME_SPACEATTACK:
			begin
				ports_next.p1 = {~p1.left, ~p2.left, ~p2.right, ~p2.fire1,
					~ctrl.start2, ~ctrl.start1, ~p1.fire1, ~p1.right};
				ports_next.p3 = {dip0[4], 2'b11, dip0[3], sa_lives, dip0[0]};
			end
			default:
			begin
				ports_next = '1;
			end
		endcase
	end

	// Idle ports read as all ones
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ports <= '1;
		end
		else
		begin
			ports <= ports_next;
		end
	end

endmodule

//--- logic/loader_pkg.sv
package loader_pkg;

	// Byte address on the download stream and the memory port
	typedef logic [24:0] dl_addr_t;

	typedef struct packed
	{
		logic download;
		logic wr;
		logic [7:0] index;
		dl_addr_t addr;
		logic [7:0] data;
	} dl_stream_t;

	// Loader index values
	localparam logic [7:0] INDEX_GAME = 8'd1;
	localparam logic [7:0] INDEX_SAMPLES = 8'd2;
	localparam logic [7:0] INDEX_DIPS = 8'd254;

	// Read request from the sound core
	typedef struct packed
	{
		dl_addr_t addr;
		logic rd;
	} sample_req_t;

	typedef struct packed
	{
		dl_addr_t addr;
		logic we;
		logic rd;
		logic [7:0] din;
	} mem_cmd_t;

endpackage

//--- logic/sample_fetch.sv
module sample_fetch
	import loader_pkg::*;
(
	input  logic clk_sys,
	input  logic arst_n,
	input  dl_stream_t dl,
	input  sample_req_t sample_req,
	input  logic mem_ready,
	input  logic [15:0] mem_dout,
	output mem_cmd_t mem_cmd,
	output logic [7:0] sample_byte,
	output logic sample_ack
);

	logic sample_download;
	logic ready_d;

	// Wave download has priority over core reads
	assign sample_download = dl.download && dl.wr && (dl.index == INDEX_SAMPLES);

	assign mem_cmd.addr = sample_download ? dl.addr : sample_req.addr;
	assign mem_cmd.we = sample_download;
	assign mem_cmd.rd = !sample_download && sample_req.rd;
	assign mem_cmd.din = dl.data;

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ready_d <= 1'b0;
			sample_byte <= '0;
			sample_ack <= 1'b0;
		end
		else
		begin
			ready_d <= mem_ready;
			// One completion per rising edge of ready
			if (mem_ready && !ready_d)
			begin
				sample_byte <= sample_req.addr[0] ? mem_dout[15:8] : mem_dout[7:0];
				sample_ack <= !sample_ack;
			end
		end
	end

endmodule

//--- logic/vicdual_io.sv
module vicdual_io
	import loader_pkg::*, cabinet_pkg::*;
#(
	parameter int DIP_BYTES = 8
)
(
	input  logic clk_sys,
	input  logic arst_n,
	input  dl_stream_t dl,
	input  logic reset_request,
	input  cabinet_ctrl_t ctrl,
	input  sample_req_t sample_req,
	input  logic mem_ready,
	input  logic [15:0] mem_dout,
	output logic core_reset,
	output game_t game_mode,
	output in_ports_t ports,
	output mem_cmd_t mem_cmd,
	output logic [7:0] sample_byte,
	output logic sample_ack
);

	logic [7:0] dip0;

	download_regs #(
		.DIP_BYTES(DIP_BYTES)
	) i_download_regs (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.dl(dl),
		.reset_request(reset_request),
		.game_mode(game_mode),
		.dip0(dip0),
		.core_reset(core_reset)
	);

	input_port_encoder i_input_port_encoder (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.game_mode(game_mode),
		.dip0(dip0),
		.ctrl(ctrl),
		.ports(ports)
	);

	sample_fetch i_sample_fetch (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.dl(dl),
		.sample_req(sample_req),
		.mem_ready(mem_ready),
		.mem_dout(mem_dout),
		.mem_cmd(mem_cmd),
		.sample_byte(sample_byte),
		.sample_ack(sample_ack)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the vicdual_io testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vicdual_io.f --top-module vicdual_io_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vvicdual_io_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tests/vicdual_io_assert.sv
module vicdual_io_assert
	import loader_pkg::*;
(
	input  logic clk_sys,
	input  logic arst_n,
	input  mem_cmd_t mem_cmd,
	input  logic core_reset,
	input  logic rom_loaded,
	input  logic mem_ready,
	input  logic sample_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// One owner of the memory port per cycle
	we_rd_exclusive: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(mem_cmd.we && mem_cmd.rd))
	else
	begin
		fail_count++;
		$error("memory port has write and read high together");
	end

	reset_until_loaded: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!rom_loaded |-> core_reset)
	else
	begin
		fail_count++;
		$error("core left reset before the ROM was loaded");
	end

	// Toggle only right after a rising ready
	ack_on_ready_rise: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(sample_ack != $past(sample_ack)) |-> ($past(mem_ready) && !$past(mem_ready, 2)))
	else
	begin
		fail_count++;
		$error("sample acknowledge toggled without a rising ready");
	end

endmodule

bind vicdual_io vicdual_io_assert i_vicdual_io_assert (
	.clk_sys(clk_sys),
	.arst_n(arst_n),
	.mem_cmd(mem_cmd),
	.core_reset(core_reset),
	.rom_loaded(i_download_regs.rom_loaded),
	.mem_ready(mem_ready),
	.sample_ack(sample_ack)
);

//--- tests/vicdual_io_model.svh
`ifndef VICDUAL_IO_MODEL_SVH
`define VICDUAL_IO_MODEL_SVH

// Mirror of the DUT state
game_t m_game;
logic [7:0] m_dip [DIP_BYTES];
logic m_rom_loaded;
logic m_ready_last;

function automatic void model_reset();
	m_game = '0;
	for (int i = 0; i < DIP_BYTES; i++)
	begin
		m_dip[i] = 8'h00;
	end
	m_rom_loaded = 1'b0;
	m_ready_last = 1'b0;
endfunction

function automatic void model_dl_write(input dl_stream_t d);
	if (d.wr && d.index == INDEX_GAME)
	begin
		m_game = d.data[4:0];
	end
	if (d.wr && d.index == INDEX_DIPS && d.addr < dl_addr_t'(DIP_BYTES))
	begin
		m_dip[d.addr[2:0]] = d.data;
	end
endfunction

function automatic logic is_supported(input game_t g);
	return g inside {GAME_CARNIVAL, GAME_DIGGER, GAME_FROGS, GAME_HEADON,
		GAME_HEIANKYO, GAME_SPACEATTACK};
endfunction

function automatic logic [7:0] pick_byte(input dl_addr_t a, input logic [15:0] w);
	return a[0] ? w[15:8] : w[7:0];
endfunction

// Port layouts, bit by bit, untouched bits stay 1
function automatic in_ports_t model_ports(input game_t g, input logic [7:0] d,
	input cabinet_ctrl_t c);
	in_ports_t r;
	player_ctrl_t a;
	player_ctrl_t b;
	logic apart;
	r = '1;
	apart = (g == GAME_HEIANKYO) && (d[0] == 1'b0);
	a = apart ? c.p1 : (c.p1 | c.p2);
	b = apart ? c.p2 : (c.p1 | c.p2);
	case (g)
		GAME_CARNIVAL:
		begin
			r.p1[4] = d[0];
			r.p2[5] = ~a.right;
			r.p2[4] = ~a.left;
			r.p2[2] = 1'b0;
			r.p3[5] = ~a.fire1;
			r.p3[4] = ~c.start1;
			r.p4[5] = ~c.start2;
		end
		GAME_DIGGER:
		begin
			r.p1 = ~{a.up, a.left, a.down, a.right, a.fire2, a.fire1, c.start2, c.start1};
			r.p3[1:0] = d[1:0];
		end
		GAME_FROGS:
		begin
			r.p1[7] = ~a.fire1;
			r.p1[6:3] = d[3:0];
			r.p1[2:0] = ~{a.left, a.up, a.right};
		end
		GAME_HEADON:
		begin
			r.p1[7:3] = ~{a.up, a.left, a.down, a.right, a.fire1};
			r.p1[2:0] = {d[0], d[2], d[1]};
		end
		GAME_HEIANKYO:
		begin
			r.p1[5:3] = {~a.fire1, ~a.up, d[0]};
			r.p1[1:0] = ~{b.fire2, b.up};
			r.p2[5:3] = {~a.fire2, ~a.right, 1'b0};
			r.p2[1:0] = ~{b.fire2, b.right};
			r.p3[5:4] = {1'b0, ~a.down};
			r.p3[1:0] = {1'b0, ~a.down};
			r.p4[5:4] = ~{c.start1, a.left};
			r.p4[2:0] = {d[1], ~c.start2, ~b.left};
		end
		GAME_SPACEATTACK:
		begin
			r.p1 = ~{a.left, b.left, b.right, b.fire1, c.start2, c.start1, a.fire1, a.right};
			r.p3[7] = d[4];
			r.p3[4] = d[3];
			case (d[2:1])
				2'd0: r.p3[3:1] = 3'd7;
				2'd1: r.p3[3:1] = 3'd6;
				2'd2: r.p3[3:1] = 3'd5;
				default: r.p3[3:1] = 3'd3;
			endcase
			r.p3[0] = d[0];
		end
		default:
		begin
			r = '1;
		end
	endcase
	return r;
endfunction

`endif

//--- tests/vicdual_io_tb.sv
module vicdual_io_tb
	import loader_pkg::*, cabinet_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DIP_BYTES = 8;
	localparam int CLK_PERIOD = 8;
	localparam int PORT_CYCLES = 200;
	localparam int READ_CYCLES = 300;
	localparam int STIM_CYCLES = 16 + 60 + 8 * (PORT_CYCLES + 10) + 20 * 10 + READ_CYCLES + 60;

	logic clk_sys = 1'b0;
	logic arst_n;
	dl_stream_t dl;
	logic reset_request;
	cabinet_ctrl_t ctrl;
	sample_req_t sample_req;
	logic mem_ready;
	logic [15:0] mem_dout;
	logic core_reset;
	game_t game_mode;
	in_ports_t ports;
	mem_cmd_t mem_cmd;
	logic [7:0] sample_byte;
	logic sample_ack;

	int seed = 98560;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	`include "vicdual_io_model.svh"

	vicdual_io #(
		.DIP_BYTES(DIP_BYTES)
	) i_vicdual_io (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got == exp)
		else
		begin
			$display("MISMATCH %s: expected %h, got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int mark);
		if (errors == mark)
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - mark);
		end
	endtask

	task automatic dl_write(input logic [7:0] idx, input dl_addr_t a, input logic [7:0] d);
		dl_stream_t beat;
		beat = '{1'b0, 1'b1, idx, a, d};
		@(posedge clk_sys);
		dl <= beat;
		@(posedge clk_sys);
		dl <= '0;
		model_dl_write(beat);
	endtask

	task automatic core_reset_after(input int n, input logic exp);
		repeat (n) @(posedge clk_sys);
		@(negedge clk_sys);
		check("core_reset", 64'(core_reset), 64'(exp));
	endtask

	initial
	begin
		game_t games [8];
		game_t code;
		logic [7:0] dip_val;
		logic [7:0] idx;
		cabinet_ctrl_t c;
		in_ports_t exp_ports;
		in_ports_t held;
		dl_stream_t beat;
		sample_req_t req;
		logic rdy;
		logic [15:0] dout;
		logic [7:0] exp_byte;
		logic exp_ack;
		mem_cmd_t exp_cmd;
		int mark;
		arst_n <= 1'b0;
		dl <= '0;
		reset_request <= 1'b0;
		ctrl <= '0;
		sample_req <= '0;
		mem_ready <= 1'b0;
		mem_dout <= '0;
		model_reset();
		repeat (16) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);

		mark = errors;
		check("core_reset", 64'(core_reset), 64'd1);
		check("ports", 64'(ports), 64'h0000_0000_ffff_ffff);
		check("sample_ack", 64'(sample_ack), 64'd0);
		check("game_mode", 64'(game_mode), 64'(m_game));
		finish_test("reset values", mark);

		// ROM download, then the menu reset
		mark = errors;
		for (int i = 0; i < 24; i++)
		begin
			@(posedge clk_sys);
			dl <= '{1'b1, 1'b1, 8'd0, dl_addr_t'(i), 8'(rand32())};
			@(negedge clk_sys);
			check("core_reset", 64'(core_reset), 64'd1);
		end
		@(posedge clk_sys);
		dl <= '0;
		core_reset_after(0, 1'b1);
		core_reset_after(1, !m_rom_loaded);
		m_rom_loaded = 1'b1;
		core_reset_after(1, !m_rom_loaded);
		@(posedge clk_sys);
		reset_request <= 1'b1;
		core_reset_after(0, !m_rom_loaded);
		core_reset_after(1, 1'b1);
		@(posedge clk_sys);
		reset_request <= 1'b0;
		core_reset_after(1, !m_rom_loaded);
		finish_test("rom load and core reset", mark);

		games = '{GAME_CARNIVAL, GAME_DIGGER, GAME_FROGS, GAME_HEADON,
			GAME_HEIANKYO, GAME_HEIANKYO, GAME_SPACEATTACK, 5'd0};
		for (int g = 0; g < 8; g++)
		begin
			mark = errors;
			code = games[g];
			if (g == 7)
			begin
				code = 5'(rand32());
				while (is_supported(code))
				begin
					code = 5'(rand32());
				end
			end
			dip_val = 8'(rand32());
			// Heiankyo once merged and once simultaneous
			if (g == 4)
				dip_val[0] = 1'b0;
			if (g == 5)
				dip_val[0] = 1'b1;
			dl_write(INDEX_GAME, '0, {3'b000, code});
			dl_write(INDEX_DIPS, '0, dip_val);
			@(posedge clk_sys);
			@(negedge clk_sys);
			check("game_mode", 64'(game_mode), 64'(m_game));
			exp_ports = model_ports(m_game, m_dip[0], ctrl);
			for (int i = 0; i < PORT_CYCLES; i++)
			begin
				c = cabinet_ctrl_t'(16'(rand32()));
				@(posedge clk_sys);
				ctrl <= c;
				@(negedge clk_sys);
				check("ports", 64'(ports), 64'(exp_ports));
				exp_ports = model_ports(m_game, m_dip[0], c);
			end
			finish_test($sformatf("ports for mode %0d", code), mark);
		end

		mark = errors;
		dl_write(INDEX_GAME, '0, {3'b000, GAME_SPACEATTACK});
		dl_write(INDEX_DIPS, '0, 8'(rand32()));
		@(posedge clk_sys);
		@(negedge clk_sys);
		held = model_ports(m_game, m_dip[0], ctrl);
		check("ports", 64'(ports), 64'(held));
		for (int i = 0; i < 20; i++)
		begin
			dl_write(INDEX_DIPS, dl_addr_t'(DIP_BYTES) + dl_addr_t'(rand32() & 32'hfff),
				8'(rand32()));
			idx = INDEX_GAME;
			while (idx == INDEX_GAME || idx == INDEX_DIPS)
			begin
				idx = 8'(rand32());
			end
			dl_write(idx, dl_addr_t'(rand32() & 32'h7), 8'(rand32()));
			@(posedge clk_sys);
			@(negedge clk_sys);
			check("ports", 64'(ports), 64'(held));
			check("game_mode", 64'(game_mode), 64'(GAME_SPACEATTACK));
		end
		finish_test("ignored writes", mark);

		mark = errors;
		exp_byte = 8'h00;
		exp_ack = 1'b0;
		for (int i = 0; i < READ_CYCLES; i++)
		begin
			req = '{dl_addr_t'(rand32()), 1'(rand32())};
			rdy = 1'(rand32());
			dout = 16'(rand32());
			@(posedge clk_sys);
			sample_req <= req;
			mem_ready <= rdy;
			mem_dout <= dout;
			@(negedge clk_sys);
			check("sample_byte", 64'(sample_byte), 64'(exp_byte));
			check("sample_ack", 64'(sample_ack), 64'(exp_ack));
			exp_cmd = '{req.addr, 1'b0, req.rd, 8'h00};
			check("mem_cmd", 64'(mem_cmd), 64'(exp_cmd));
			if (rdy && !m_ready_last)
			begin
				exp_byte = pick_byte(req.addr, dout);
				exp_ack = ~exp_ack;
			end
			m_ready_last = rdy;
		end
		finish_test("sample reads", mark);

		// Wave download takes the memory port from the core
		mark = errors;
		for (int i = 0; i < 40; i++)
		begin
			beat = '{1'b1, 1'b1, INDEX_SAMPLES, dl_addr_t'(rand32()), 8'(rand32())};
			@(posedge clk_sys);
			dl <= beat;
			sample_req <= '{dl_addr_t'(rand32()), 1'b1};
			mem_ready <= 1'b0;
			@(negedge clk_sys);
			check("mem_cmd", 64'(mem_cmd), 64'(mem_cmd_t'({beat.addr, 1'b1, 1'b0, beat.data})));
			check("sample_byte", 64'(sample_byte), 64'(exp_byte));
			check("sample_ack", 64'(sample_ack), 64'(exp_ack));
		end
		@(posedge clk_sys);
		dl <= '0;
		finish_test("sample download", mark);

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (errors == 0 && tests_failed == 0 && i_vicdual_io.i_vicdual_io_assert.fail_count == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial
	begin
		#((STIM_CYCLES + 200) * CLK_PERIOD);
		$display("timeout: tests still running after %0d cycles", STIM_CYCLES + 200);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- vicdual_io.f
+incdir+tests
logic/loader_pkg.sv
logic/cabinet_pkg.sv
logic/download_regs.sv
logic/input_port_encoder.sv
logic/sample_fetch.sv
logic/vicdual_io.sv
tests/vicdual_io_assert.sv
tests/vicdual_io_tb.sv
